// File: direct_mapped_cache.f
hdl/cache_pkg.sv
hdl/cache_array_if.sv
hdl/cache_store.sv
hdl/cache_ctrl.sv
hdl/direct_mapped_cache.sv
tb/mem_model.sv
tb/tb_direct_mapped_cache.sv

// File: Makefile
# Verilator flow for the direct-mapped cache
VERILATOR ?= verilator
TOP       ?= tb_direct_mapped_cache
FILELIST  ?= direct_mapped_cache.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert -Wno-fatal
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# Pass only when the pass line shows up in the output
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tb/tb_direct_mapped_cache.sv
`timescale 1ns/1ns
`default_nettype none

module tb_direct_mapped_cache;

    localparam int NUM_ROWS       = 17;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 40 + 200;

    typedef struct {
        string       name;
        logic        rw;       // 1 write
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        chk;      // Compare read data
        logic        hit;      // 4-edge latency, no refill
        logic        wb;       // One write-back expected
    } row_t;

    logic         clk;
    logic         rst;
    logic         cpu_req;
    logic         cpu_rw;
    logic [31:0]  cpu_addr;
    logic [31:0]  cpu_wdata;
    logic [3:0]   cpu_wstrb;
    logic         cpu_ready;
    logic         cpu_resp;
    logic [31:0]  cpu_rdata;
    logic         mem_req;
    logic         mem_rw;
    logic [31:0]  mem_addr;
    logic [255:0] mem_wdata;
    logic         mem_ready;
    logic         mem_resp;
    logic [255:0] mem_rdata;
    int           wr_cnt;
    int           rd_cnt;

    row_t         tbl [NUM_ROWS];
    logic [31:0]  shadow [logic [31:0]];   // Words written so far
    int           errors;
    int           rd_base;                 // Read count at start of row
    string        cur_name;
    int           i;
    logic         ready_q;                 // mem_ready one edge back

    direct_mapped_cache direct_mapped_cache_inst (.*);

    mem_model #(.SEED(33)) u_mem (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // --------------------------------------------------
    // Shadow memory of pattern plus merged writes
    // --------------------------------------------------
    function automatic logic [31:0] shadow_word(input logic [31:0] a);
        logic [31:0] wa;
        wa = {a[31:2], 2'b00};
        if (shadow.exists(wa)) begin
            return shadow[wa];
        end
        return wa ^ 32'hC0DE0000;
    endfunction

    task automatic shadow_write(input logic [31:0] a, input logic [31:0] d, input logic [3:0] s);
        logic [31:0] w;
        int          b;
        w = shadow_word(a);
        for (b = 0; b < 4; b++) begin
            if (s[b]) begin
                w[b*8 +: 8] = d[b*8 +: 8];   // Enabled bytes only
            end
        end
        shadow[{a[31:2], 2'b00}] = w;
    endtask

    task automatic set_row(input int idx, input string name, input logic rw,
                           input logic [31:0] addr, input logic [31:0] wdata,
                           input logic [3:0] wstrb, input logic chk, input logic hit,
                           input logic wb);
        tbl[idx] = '{name, rw, addr, wdata, wstrb, chk, hit, wb};
    endtask

    // Set 2 sees tags 0x4, 0x14, 0xC; set 4 sees tags 0x8, 0x18
    task automatic build_table();
        set_row(0,  "rd_miss",        0, 32'h0000_1040, 32'h0,          4'h0, 1, 0, 0);
        set_row(1,  "rd_hit",         0, 32'h0000_1044, 32'h0,          4'h0, 1, 1, 0);
        set_row(2,  "wr_hit_part",    1, 32'h0000_1044, 32'hAABB_CCDD,  4'h5, 0, 1, 0);
        set_row(3,  "rd_after_wr",    0, 32'h0000_1044, 32'h0,          4'h0, 1, 1, 0);
        set_row(4,  "wr_miss_alloc",  1, 32'h0000_2088, 32'h1122_3344,  4'hF, 0, 0, 0);
        set_row(5,  "rd_neighbor",    0, 32'h0000_208C, 32'h0,          4'h0, 1, 1, 0);
        set_row(6,  "rd_merged",      0, 32'h0000_2088, 32'h0,          4'h0, 1, 1, 0);
        set_row(7,  "evict_dirty",    0, 32'h0000_5040, 32'h0,          4'h0, 1, 0, 1);
        set_row(8,  "reread_via_mem", 0, 32'h0000_1044, 32'h0,          4'h0, 1, 0, 0);
        set_row(9,  "evict_clean",    0, 32'h0000_3040, 32'h0,          4'h0, 1, 0, 0);
        set_row(10, "wr_hit_byte",    1, 32'h0000_2090, 32'h5A00_0000,  4'h8, 0, 1, 0);
        set_row(11, "wr_miss_dirty",  1, 32'h0000_6084, 32'h0000_BEEF,  4'h3, 0, 0, 1);
        set_row(12, "rd_wr_alloc",    0, 32'h0000_6084, 32'h0,          4'h0, 1, 1, 0);
        set_row(13, "rd_neighbor2",   0, 32'h0000_609C, 32'h0,          4'h0, 1, 1, 0);
        set_row(14, "reread_byte",    0, 32'h0000_2090, 32'h0,          4'h0, 1, 0, 1);
        set_row(15, "rd_top_set",     0, 32'hFFFF_FFFC, 32'h0,          4'h0, 1, 0, 0);
        set_row(16, "rd_top_hit",     0, 32'hFFFF_FFE0, 32'h0,          4'h0, 1, 1, 0);
    endtask

    // --------------------------------------------------
    // One CPU transaction
    // --------------------------------------------------
    task automatic apply_row(input int idx);
        row_t        r;
        int          edges;
        int          wr0;
        logic [31:0] exp_rd;
        r        = tbl[idx];
        cur_name = r.name;
        wr0      = wr_cnt;
        rd_base  = rd_cnt;
        exp_rd   = shadow_word(r.addr);
        cpu_req   <= 1'b1;
        cpu_rw    <= r.rw;
        cpu_addr  <= r.addr;
        cpu_wdata <= r.wdata;
        cpu_wstrb <= r.wstrb;
        @(posedge clk);                            // Accepting edge
        if (!cpu_ready) begin
            errors++;
            $display("%s: cpu_ready was low when the request was offered", r.name);
        end
        cpu_req <= 1'b0;
        edges = 0;
        do begin
            @(posedge clk);
            edges++;
            if (!cpu_resp && cpu_ready) begin
                errors++;
                $display("%s: cpu_ready high before cpu_resp", r.name);
            end
        end while (!cpu_resp);
        if (r.chk && cpu_rdata !== exp_rd) begin
            errors++;
            $display("ERR %s: expected %h, actual %h", r.name, exp_rd, cpu_rdata);
        end
        if (r.hit && edges != 4) begin
            errors++;
            $display("ERR %s latency: expected %0d, actual %0d", r.name, 4, edges);
        end
        if ((rd_cnt - rd_base) != (r.hit ? 0 : 1)) begin
            errors++;
            $display("ERR %s refills: expected %0d, actual %0d", r.name, r.hit ? 0 : 1,
                     rd_cnt - rd_base);
        end
        if ((wr_cnt - wr0) != int'(r.wb)) begin
            errors++;
            $display("ERR %s write-backs: expected %0d, actual %0d", r.name, r.wb, wr_cnt - wr0);
        end
        if (r.rw) begin
            shadow_write(r.addr, r.wdata, r.wstrb);
        end
    endtask

    // Victim block must match the shadow and come before the refill
    task automatic check_writeback(input logic [31:0] a, input logic [255:0] blk);
        int          w;
        logic [31:0] exp_w;
        if (rd_cnt != rd_base) begin
            errors++;
            $display("%s: write-back issued after the refill read", cur_name);
        end
        for (w = 0; w < 8; w++) begin
            exp_w = shadow_word(a + 32'(w * 4));
            if (blk[w*32 +: 32] !== exp_w) begin
                errors++;
                $display("ERR %s wb %h word %0d: expected %h, actual %h", cur_name, a, w,
                         exp_w, blk[w*32 +: 32]);
            end
        end
    endtask

    always @(posedge clk) begin
        if (!rst && mem_req && mem_rw) begin
            check_writeback(mem_addr, mem_wdata);
        end
    end

    // mem_req may only follow a cycle with mem_ready high
    always @(posedge clk) begin
        if (!rst && mem_req && !ready_q) begin
            errors++;
            $display("%s: mem_req issued while mem_ready was low", cur_name);
        end
        ready_q <= mem_ready;
    end

    // --------------------------------------------------
    // Main sequence and watchdog
    // --------------------------------------------------
    initial begin
        rst       = 1'b1;
        cpu_req   = 1'b0;
        cpu_rw    = 1'b0;
        cpu_addr  = '0;
        cpu_wdata = '0;
        cpu_wstrb = '0;
        errors    = 0;
        rd_base   = 0;
        cur_name  = "reset";
        build_table();
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        for (i = 0; i < NUM_ROWS; i++) begin
            apply_row(i);
        end
        $display("Rows run: %0d, errors: %0d", NUM_ROWS, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles in %s, no cpu_resp", TIMEOUT_CYCLES, cur_name);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/mem_model.sv
`timescale 1ns/1ns
`default_nettype none

// Block-wide memory behind the cache, random ready stalls and response delay
module mem_model #(
    parameter int SEED = 33
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         mem_req,
    input  logic         mem_rw,        // 1 block write
    input  logic [31:0]  mem_addr,
    input  logic [255:0] mem_wdata,
    output logic         mem_ready,
    output logic         mem_resp,
    output logic [255:0] mem_rdata,     // Held until next request
    output int           wr_cnt,        // Block writes requested
    output int           rd_cnt         // Block reads requested
);
    logic [31:0]  words [logic [31:0]];   // Only words that were written
    logic         busy;
    logic         op_rw;
    logic [31:0]  op_addr;
    logic [255:0] op_wdata;
    int           delay;                  // Edges left until mem_resp
    int           stall;                  // Edges left with mem_ready low
    integer       seed;

    initial seed = SEED;

    // Untouched words follow the address pattern
    function automatic logic [31:0] word_at(input logic [31:0] a);
        if (words.exists(a)) begin
            return words[a];
        end
        return a ^ 32'hC0DE0000;
    endfunction

    function automatic logic [255:0] read_block(input logic [31:0] base);
        logic [255:0] blk;
        int           w;
        for (w = 0; w < 8; w++) begin
            blk[w*32 +: 32] = word_at(base + 32'(w * 4));
        end
        return blk;
    endfunction

    task automatic write_block(input logic [31:0] base, input logic [255:0] blk);
        int w;
        for (w = 0; w < 8; w++) begin
            words[base + 32'(w * 4)] = blk[w*32 +: 32];
        end
    endtask

    // --------------------------------------------------
    // Request, delay, response
    // --------------------------------------------------
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            mem_ready <= 1'b0;
            mem_resp  <= 1'b0;
            mem_rdata <= '0;
            busy      <= 1'b0;
            delay     <= 0;
            stall     <= 2;                       // Short stall out of reset
            wr_cnt    <= 0;
            rd_cnt    <= 0;
        end else begin
            mem_resp <= 1'b0;
            if (mem_req) begin
                busy      <= 1'b1;
                mem_ready <= 1'b0;
                op_rw     <= mem_rw;
                op_addr   <= mem_addr;
                op_wdata  <= mem_wdata;
                delay     <= 1 + int'($unsigned($random(seed)) % 4);   // Resp 2..5 after req
                if (mem_rw) begin
                    wr_cnt <= wr_cnt + 1;
                end else begin
                    rd_cnt <= rd_cnt + 1;
                end
            end else if (busy) begin
                if (delay > 1) begin
                    delay <= delay - 1;
                end else begin
                    busy     <= 1'b0;
                    mem_resp <= 1'b1;
                    stall    <= int'($unsigned($random(seed)) % 4);    // 0..3 idle cycles
                    if (op_rw) begin
                        write_block(op_addr, op_wdata);
                    end else begin
                        mem_rdata <= read_block(op_addr);
                    end
                end
            end else if (stall > 0) begin
                stall <= stall - 1;
            end else begin
                mem_ready <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/direct_mapped_cache.sv
`timescale 1ns/1ns
`default_nettype none

// 1 KB direct-mapped, write-back, write-allocate data cache
module direct_mapped_cache (
    input  logic              clk,
    input  logic              rst,

    // --------------------------------------------------
    // CPU port
    // --------------------------------------------------
    input  logic              cpu_req,
    input  logic              cpu_rw,       // 0 read, 1 write
    input  cache_pkg::addr_t  cpu_addr,
    input  cache_pkg::word_t  cpu_wdata,
    input  cache_pkg::strb_t  cpu_wstrb,    // Byte enables
    output logic              cpu_ready,
    output logic              cpu_resp,
    output cache_pkg::word_t  cpu_rdata,

    // --------------------------------------------------
    // Memory port, one block per transfer
    // --------------------------------------------------
    output logic              mem_req,
    output logic              mem_rw,       // 1 for write-back
    output cache_pkg::addr_t  mem_addr,     // Block aligned
    output cache_pkg::block_t mem_wdata,
    input  logic              mem_ready,
    input  logic              mem_resp,
    input  cache_pkg::block_t mem_rdata
);

    cache_array_if arr_if ();

    // Request handling and miss sequencing
    cache_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .cpu_req   (cpu_req),
        .cpu_rw    (cpu_rw),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_wstrb (cpu_wstrb),
        .cpu_ready (cpu_ready),
        .cpu_resp  (cpu_resp),
        .cpu_rdata (cpu_rdata),
        .mem_req   (mem_req),
        .mem_rw    (mem_rw),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ready (mem_ready),
        .mem_resp  (mem_resp),
        .mem_rdata (mem_rdata),
        .arr       (arr_if.ctrl)
    );

    // Tags, state bits and data lines
    cache_store u_store (
        .clk (clk),
        .rst (rst),
        .arr (arr_if.store)
    );

endmodule

`default_nettype wire

// File: hdl/cache_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module cache_ctrl (
    input  logic              clk,
    input  logic              rst,

    // CPU side
    input  logic              cpu_req,
    input  logic              cpu_rw,      // 0 read, 1 write
    input  cache_pkg::addr_t  cpu_addr,
    input  cache_pkg::word_t  cpu_wdata,
    input  cache_pkg::strb_t  cpu_wstrb,
    output logic              cpu_ready,
    output logic              cpu_resp,
    output cache_pkg::word_t  cpu_rdata,

    // Memory side
    output logic              mem_req,
    output logic              mem_rw,      // 0 read, 1 write
    output cache_pkg::addr_t  mem_addr,
    output cache_pkg::block_t mem_wdata,
    input  logic              mem_ready,
    input  logic              mem_resp,
    input  cache_pkg::block_t mem_rdata,

    cache_array_if.ctrl       arr
);
    import cache_pkg::*;

    ctrl_state_t state;
    ctrl_state_t next_state;

    // Latched request
    addr_t req_addr;
    word_t req_wdata;
    strb_t req_wstrb;
    logic  req_rw;

    logic  accept;                                   // Request taken this cycle

    assign accept = (state == IDLE) && cpu_req && cpu_ready;

    // --------------------------------------------------
    // Storage side
    // --------------------------------------------------
    assign arr.index      = req_addr[OFFSET_WIDTH +: INDEX_WIDTH];
    assign arr.tag        = req_addr[ADDR_WIDTH-1 -: TAG_WIDTH];
    assign arr.word_sel   = req_addr[OFFSET_WIDTH-1 -: WORD_SEL_WIDTH];   // Bits 4..2
    assign arr.wdata      = req_wdata;
    assign arr.wstrb      = req_wstrb;
    assign arr.write_word = (state == HIT) && req_rw;                     // Write hit only
    assign arr.fill       = (state == UPDATE);
    assign arr.fill_block = mem_rdata;               // Stable until next mem_req
    assign arr.fill_dirty = req_rw;                  // Write miss leaves line dirty
    assign arr.fill_merge = req_rw;

    // --------------------------------------------------
    // Next state
    // --------------------------------------------------
    always_comb begin
        next_state = state;
        case (state)
            IDLE:       if (accept) next_state = COMPARE;
            COMPARE:    next_state = arr.hit ? HIT : MISS_CHECK;
            HIT:        next_state = RESP;
            MISS_CHECK: begin
                // Only a dirty valid victim needs to go out first
                if (arr.valid && arr.dirty) begin
                    next_state = WB_INIT;
                end else begin
                    next_state = ALLOC_INIT;
                end
            end
            WB_INIT:    if (mem_ready) next_state = WB_WAIT;
            WB_WAIT:    if (mem_resp) next_state = ALLOC_INIT;
            ALLOC_INIT: if (mem_ready) next_state = ALLOC_WAIT;
            ALLOC_WAIT: if (mem_resp) next_state = UPDATE;
            UPDATE:     next_state = RESP;
            RESP:       next_state = IDLE;
            default:    next_state = IDLE;
        endcase
    end

    // --------------------------------------------------
    // Control registers
    // --------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= IDLE;
            cpu_ready <= 1'b1;
            cpu_resp  <= 1'b0;
            mem_req   <= 1'b0;
            mem_rw    <= 1'b0;
        end else begin
            state    <= next_state;
            cpu_resp <= 1'b0;                        // Single-cycle pulses
            mem_req  <= 1'b0;
            if (accept) begin
                cpu_ready <= 1'b0;                   // Busy until response
            end
            if (state == WB_INIT && mem_ready) begin
                mem_req <= 1'b1;
                mem_rw  <= 1'b1;                     // Block write
            end
            if (state == ALLOC_INIT && mem_ready) begin
                mem_req <= 1'b1;
                mem_rw  <= 1'b0;                     // Block read
            end
            if (state == RESP) begin
                cpu_resp  <= 1'b1;
                cpu_ready <= 1'b1;                   // Same cycle as resp
            end
        end
    end

    // --------------------------------------------------
    // Payload registers
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr  <= cpu_addr;
            req_wdata <= cpu_wdata;
            req_wstrb <= cpu_wstrb;
            req_rw    <= cpu_rw;
        end
        // Victim block at its own tag and index
        if (state == WB_INIT && mem_ready) begin
            mem_addr  <= {arr.victim_tag, arr.index, {OFFSET_WIDTH{1'b0}}};
            mem_wdata <= arr.line_block;
        end
        if (state == ALLOC_INIT && mem_ready) begin
            mem_addr <= {req_addr[ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};
        end
        // Line is current here on both hit and refill paths
        if (state == RESP && !req_rw) begin
            cpu_rdata <= arr.rd_word;
        end
    end

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------
    a_mem_req_after_ready: assert property (
        @(posedge clk) disable iff (rst)
        $rose(mem_req) |-> $past(mem_ready)
    ) else $error("mem_req without prior mem_ready");

    a_resp_only_when_busy: assert property (
        @(posedge clk) disable iff (rst)
        $rose(cpu_resp) |-> !$past(cpu_ready)
    ) else $error("cpu_resp while cpu_ready was high");

endmodule

`default_nettype wire

// File: hdl/cache_store.sv
`timescale 1ns/1ns
`default_nettype none

module cache_store (
    input  logic         clk,
    input  logic         rst,
    cache_array_if.store arr
);
    import cache_pkg::*;

    // --------------------------------------------------
    // Line storage
    // --------------------------------------------------
    logic [NUM_SETS-1:0] valid_q;            // Per-set valid
    logic [NUM_SETS-1:0] dirty_q;            // Per-set dirty
    tag_t                tag_q  [NUM_SETS];
    block_t              data_q [NUM_SETS];

    block_t              hit_line_merged;    // Line with wdata merged in
    block_t              fill_line_merged;   // Fill block with wdata merged in
    block_t              fill_line;          // What actually gets installed

    // Overlay one word of blk with the strobed bytes of wd
    function automatic block_t merge_block(
        input block_t    blk,
        input word_sel_t sel,
        input word_t     wd,
        input strb_t     st
    );
        block_t res;
        word_t  w;
        int     b;
        res = blk;
        w   = blk[sel*DATA_WIDTH +: DATA_WIDTH];   // Old word
        for (b = 0; b < STRB_WIDTH; b++) begin
            if (st[b]) begin
                w[b*8 +: 8] = wd[b*8 +: 8];
            end
        end
        res[sel*DATA_WIDTH +: DATA_WIDTH] = w;
        return res;
    endfunction

    // --------------------------------------------------
    // Lookup is purely combinational
    // --------------------------------------------------
    assign arr.valid      = valid_q[arr.index];
    assign arr.dirty      = dirty_q[arr.index];
    assign arr.victim_tag = tag_q[arr.index];
    assign arr.line_block = data_q[arr.index];
    assign arr.hit        = arr.valid && (arr.victim_tag == arr.tag);

    // Word select within the indexed line
    assign arr.rd_word    = arr.line_block[arr.word_sel*DATA_WIDTH +: DATA_WIDTH];

    // Merge paths
    assign hit_line_merged  = merge_block(arr.line_block, arr.word_sel, arr.wdata, arr.wstrb);
    assign fill_line_merged = merge_block(arr.fill_block, arr.word_sel, arr.wdata, arr.wstrb);
    assign fill_line        = arr.fill_merge ? fill_line_merged : arr.fill_block;

    // --------------------------------------------------
    // Line state bits
    // --------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;                           // All lines invalid
            dirty_q <= '0;                           // and clean
        end else if (arr.fill) begin
            valid_q[arr.index] <= 1'b1;
            dirty_q[arr.index] <= arr.fill_dirty;    // Set on write-allocate
        end else if (arr.write_word) begin
            dirty_q[arr.index] <= 1'b1;
        end
    end

    // Tag only changes on install
    always_ff @(posedge clk) begin
        if (arr.fill) begin
            tag_q[arr.index] <= arr.tag;
        end
    end

    // Data written by refill or by a hit write
    always_ff @(posedge clk) begin
        if (arr.fill) begin
            data_q[arr.index] <= fill_line;
        end else if (arr.write_word) begin
            data_q[arr.index] <= hit_line_merged;
        end
    end

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------
    // Hit write and refill come from different FSM states
    a_no_write_and_fill: assert property (
        @(posedge clk) disable iff (rst)
        !(arr.write_word && arr.fill)
    ) else $error("write_word and fill together");

endmodule

`default_nettype wire

// File: hdl/cache_array_if.sv
`timescale 1ns/1ns
`default_nettype none

// Controller <-> line storage
interface cache_array_if;
    import cache_pkg::*;

    // Lookup, driven by the controller
    index_t    index;
    tag_t      tag;
    word_sel_t word_sel;

    // Hit write
    word_t     wdata;
    strb_t     wstrb;
    logic      write_word;   // Merge wdata into line, set dirty

    // Refill install
    logic      fill;         // Write block, set valid and tag
    block_t    fill_block;
    logic      fill_dirty;   // Dirty value after install
    logic      fill_merge;   // Merge wdata into fill_block first

    // Lookup results, combinational on index/tag/word_sel
    logic      hit;
    logic      valid;
    logic      dirty;
    tag_t      victim_tag;   // Stored tag, for write-back address
    word_t     rd_word;
    block_t    line_block;

    modport ctrl (
        output index, tag, word_sel, wdata, wstrb, write_word,
        output fill, fill_block, fill_dirty, fill_merge,
        input  hit, valid, dirty, victim_tag, rd_word, line_block
    );

    modport store (
        input  index, tag, word_sel, wdata, wstrb, write_word,
        input  fill, fill_block, fill_dirty, fill_merge,
        output hit, valid, dirty, victim_tag, rd_word, line_block
    );

endinterface

`default_nettype wire

// File: hdl/cache_pkg.sv
`default_nettype none

package cache_pkg;

    // --------------------------------------------------
    // Geometry
    // --------------------------------------------------
    localparam int ADDR_WIDTH      = 32;
    localparam int DATA_WIDTH      = 32;                         // CPU word
    localparam int STRB_WIDTH      = DATA_WIDTH / 8;             // One strobe per byte
    localparam int BLOCK_BYTES     = 32;
    localparam int WORDS_PER_BLOCK = BLOCK_BYTES / STRB_WIDTH;   // 8 words
    localparam int BLOCK_BITS      = BLOCK_BYTES * 8;            // 256 bits
    localparam int NUM_SETS        = 32;                         // 1 KB total

    // Address fields, tag | index | word | byte
    localparam int OFFSET_WIDTH    = $clog2(BLOCK_BYTES);        // Bits 4..0
    localparam int WORD_SEL_WIDTH  = $clog2(WORDS_PER_BLOCK);    // Bits 4..2
    localparam int INDEX_WIDTH     = $clog2(NUM_SETS);           // Bits 9..5
    localparam int TAG_WIDTH       = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

    // --------------------------------------------------
    // Data types
    // --------------------------------------------------
    typedef logic [ADDR_WIDTH-1:0]     addr_t;
    typedef logic [DATA_WIDTH-1:0]     word_t;
    typedef logic [STRB_WIDTH-1:0]     strb_t;
    typedef logic [BLOCK_BITS-1:0]     block_t;
    typedef logic [INDEX_WIDTH-1:0]    index_t;
    typedef logic [TAG_WIDTH-1:0]      tag_t;
    typedef logic [WORD_SEL_WIDTH-1:0] word_sel_t;

    // --------------------------------------------------
    // Controller FSM
    // --------------------------------------------------
    // Hit path:  IDLE -> COMPARE -> HIT -> RESP
    // Miss path: COMPARE -> MISS_CHECK -> [WB_*] -> ALLOC_* -> UPDATE -> RESP
    typedef enum logic [3:0] {
        IDLE,         // Waiting for cpu_req
        COMPARE,      // Tag lookup on latched address
        HIT,          // Word write on write hit
        MISS_CHECK,   // Victim dirty or not
        WB_INIT,      // Wait for mem_ready, then issue block write
        WB_WAIT,      // Block write in flight
        ALLOC_INIT,   // Wait for mem_ready, then issue block read
        ALLOC_WAIT,   // Block read in flight
        UPDATE,       // Install refilled block
        RESP          // Pulse cpu_resp
    } ctrl_state_t;

endpackage

`default_nettype wire
